//--- Makefile
TOP := tb_ulpi_line

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f tb.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

//--- tb.f
verilog/ulpi_pkg.sv
verilog/ulpi_rx_cmd.sv
verilog/line_timers.sv
verilog/ulpi_reg_writer.sv
verilog/line_state.sv
verilog/ulpi_line_top.sv
tests/ulpi_line_properties.sv
tests/tb_ulpi_line.sv

//--- tests/tb_ulpi_line.sv
module tb_ulpi_line
  import ulpi_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TICK_CYCLES   = 4;
  localparam int FS_WAIT_TICKS = 6;
  localparam int MS_TICKS      = 5;
  localparam int CYCLE_LIMIT   = 20000;

  logic       clock = 1'b0;
  logic       reset;
  logic       ulpi_dir;
  logic       ulpi_nxt;
  logic [7:0] ulpi_data_in;
  logic [7:0] ulpi_data_out;
  logic       ulpi_stp;
  logic       usb_sof;
  logic       high_speed;
  logic       usb_reset;
  rx_cmd_t    line;
  phy_state_t phy_state;
  logic       idle;
  int         cycles = 0;

  ulpi_line_top #(
    .TICK_CYCLES   (TICK_CYCLES),
    .FS_WAIT_TICKS (FS_WAIT_TICKS),
    .MS_TICKS      (MS_TICKS)
  ) i_ulpi_line_top (
    .clock        (clock),
    .reset        (reset),
    .ulpi_dir_i   (ulpi_dir),
    .ulpi_nxt_i   (ulpi_nxt),
    .ulpi_data_i  (ulpi_data_in),
    .ulpi_data_o  (ulpi_data_out),
    .ulpi_stp_o   (ulpi_stp),
    .usb_sof_i    (usb_sof),
    .high_speed_o (high_speed),
    .usb_reset_o  (usb_reset),
    .line_o       (line),
    .phy_state_o  (phy_state),
    .idle_o       (idle)
  );

  always #20 clock = ~clock;

  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      stop_with_error("Timeout: the tests did not finish within the cycle limit");
    end
  end

  task automatic check_write(input string name, input phy_cmd_t exp, input phy_cmd_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("Error %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_line(input string name, input rx_cmd_t exp, input rx_cmd_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("Error %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_state(input string name, input phy_state_t exp, input phy_state_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("Error %s: expected %s actual %s", name, exp.name(), act.name()));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_error($sformatf("Error %s: expected %b actual %b", name, exp, act));
    end
  endtask

  function automatic phy_cmd_t make_cmd(input logic nopid, input logic [7:0] addr,
                                        input logic [7:0] data);
    phy_cmd_t c;
    c.nopid = nopid;
    c.addr  = addr;
    c.data  = data;
    return c;
  endfunction

  task automatic apply_reset();
    reset        = 1'b1;
    ulpi_dir     = 1'b0;
    ulpi_nxt     = 1'b0;
    ulpi_data_in = 8'h00;
    usb_sof      = 1'b0;
    repeat (16) @(posedge clock);
    #5 reset = 1'b0;
  endtask

  // PHY side of one register write or NOPID chirp
  task automatic capture_write(output phy_cmd_t got, output int busy);
    int waited;
    waited = 0;
    busy   = 0;
    got    = '0;
    @(negedge clock);
    while (ulpi_data_out == 8'h00) begin
      waited++;
      if (waited > 200) begin
        stop_with_error("No TX CMD byte appeared on the ULPI bus");
      end
      @(negedge clock);
    end
    got.addr  = ulpi_data_out;
    got.nopid = (ulpi_data_out == TXCMD_NOPID);
    @(posedge clock);
    #5 ulpi_nxt = 1'b1;
    @(posedge clock);
    if (got.nopid) begin
      #5 ulpi_nxt = 1'b0;
      @(negedge clock);
      while (!ulpi_stp) begin
        busy++;
        if (busy > 500) begin
          stop_with_error("Chirp K was never ended by stp");
        end
        @(negedge clock);
      end
    end else begin
      @(negedge clock);
      got.data = ulpi_data_out;
      @(posedge clock);
      #5 ulpi_nxt = 1'b0;
      @(negedge clock);
      if (!ulpi_stp) begin
        stop_with_error("Register write was not ended by stp");
      end
    end
    if (ulpi_data_out != 8'h00) begin
      stop_with_error("Data bus was not zero during stp");
    end
    @(negedge clock);
    if (ulpi_stp) begin
      stop_with_error("stp stayed high for more than one cycle");
    end
  endtask

  // Turnaround cycle and one RX CMD byte before the bus returns to the link
  task automatic send_rx_cmd(input rx_cmd_t value);
    @(posedge clock);
    #5 ulpi_dir = 1'b1;
    ulpi_nxt     = 1'b0;
    ulpi_data_in = 8'h00;
    @(posedge clock);
    #5 ulpi_data_in = {2'b00, value};
    @(posedge clock);
    #5 ulpi_dir = 1'b0;
    ulpi_data_in = 8'h00;
    repeat (2) @(posedge clock);
    @(negedge clock);
  endtask

  task automatic wait_for_state(input phy_state_t s, input int limit, input string name);
    int n;
    n = 0;
    while (phy_state != s) begin
      @(negedge clock);
      n++;
      if (n > limit) begin
        stop_with_error($sformatf("%s: state %s was not reached within %0d cycles",
                                  name, s.name(), limit));
      end
    end
  endtask

  task automatic test_power_on_writes();
    phy_cmd_t got;
    int       busy;
    check_line("reset_line", '{rx_event: 2'b00, vbus_state: 2'b00, line_state: K}, line);
    capture_write(got, busy);
    check_write("power_on_otg", make_cmd(1'b0, OTG_CTRL_WR, OTG_CTRL_VAL), got);
    capture_write(got, busy);
    check_write("power_on_fs", make_cmd(1'b0, FUNC_CTRL_WR, FUNC_FS), got);
    check_flag("power_on_hs", 1'b0, high_speed);
    check_flag("power_on_reset", 1'b0, usb_reset);
  endtask

  task automatic test_rx_cmd_decode();
    rx_cmd_t vec [4];
    vec[0] = '{rx_event: 2'b01, vbus_state: 2'b11, line_state: J};
    vec[1] = '{rx_event: 2'b10, vbus_state: 2'b10, line_state: SE1};
    vec[2] = '{rx_event: 2'b00, vbus_state: 2'b11, line_state: K};
    // Same line state again
    vec[3] = vec[2];
    for (int i = 0; i < 4; i++) begin
      send_rx_cmd(vec[i]);
      check_line($sformatf("rx_cmd_%0d", i), vec[i], line);
    end
  endtask

  task automatic test_fs_idle();
    wait_for_state(IDLE, 200, "fs_idle");
    check_flag("fs_idle_flag", 1'b1, idle);
    check_flag("fs_idle_hs", 1'b0, high_speed);
  endtask

  task automatic test_chirp();
    phy_cmd_t got;
    int       busy;
    line_state_t kj [6];
    kj = '{K, J, K, J, K, J};
    send_rx_cmd('{rx_event: 2'b00, vbus_state: 2'b11, line_state: SE0});
    capture_write(got, busy);
    check_write("chirp_mode", make_cmd(1'b0, FUNC_CTRL_WR, FUNC_CHIRP), got);
    capture_write(got, busy);
    check_write("chirp_nopid", make_cmd(1'b1, TXCMD_NOPID, 8'h00), got);
    if (busy < MS_TICKS * TICK_CYCLES) begin
      stop_with_error($sformatf("Chirp K was stopped after only %0d cycles", busy));
    end
    for (int i = 0; i < 6; i++) begin
      send_rx_cmd('{rx_event: 2'b00, vbus_state: 2'b11, line_state: kj[i]});
      if (i < 5) begin
        repeat (2 * TICK_CYCLES) @(posedge clock);
      end
    end
    capture_write(got, busy);
    check_write("chirp_hs", make_cmd(1'b0, FUNC_CTRL_WR, FUNC_HS), got);
    wait_for_state(IDLE, 20, "chirp_idle");
    check_flag("chirp_high_speed", 1'b1, high_speed);
  endtask

  task automatic test_bus_reset();
    phy_cmd_t got;
    int       busy;
    int       n;
    send_rx_cmd('{rx_event: 2'b00, vbus_state: 2'b11, line_state: SE0});
    n = 0;
    while (!usb_reset) begin
      @(negedge clock);
      n++;
      if (n > (3 * MS_TICKS + 2) * TICK_CYCLES + 20) begin
        stop_with_error("usb_reset_o did not rise while SE0 was held in IDLE");
      end
    end
    // Host releases the bus while the link restarts full speed
    send_rx_cmd('{rx_event: 2'b00, vbus_state: 2'b11, line_state: J});
    capture_write(got, busy);
    check_write("bus_reset_fs", make_cmd(1'b0, FUNC_CTRL_WR, FUNC_FS), got);
    check_flag("bus_reset_hs", 1'b0, high_speed);
    wait_for_state(IDLE, 100, "bus_reset_idle");
    check_flag("bus_reset_clear", 1'b0, usb_reset);
  endtask

  task automatic test_suspend();
    wait_for_state(SUSPEND, (3 * MS_TICKS + 2) * TICK_CYCLES + 20, "suspend");
    send_rx_cmd('{rx_event: 2'b00, vbus_state: 2'b11, line_state: K});
    @(posedge clock);
    @(negedge clock);
    check_state("resume_state", IDLE, phy_state);
    check_flag("resume_idle", 1'b1, idle);
  endtask

  initial begin
    apply_reset();
    test_power_on_writes();
    test_rx_cmd_decode();
    test_fs_idle();
    apply_reset();
    test_power_on_writes();
    test_chirp();
    test_bus_reset();
    test_suspend();
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- tests/ulpi_line_properties.sv
module ulpi_line_properties (
  input logic       clock,
  input logic       reset,
  input logic       dir_i,
  input logic       stp_i,
  input logic [7:0] data_i,
  input logic       cmd_valid_i,
  input logic       cmd_done_i
);
  timeunit 1ns;
  timeprecision 1ps;

  logic pending;

  // Set by a command, cleared when the writer reports it done
  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (cmd_valid_i) begin
      pending <= 1'b1;
    end else if (cmd_done_i) begin
      pending <= 1'b0;
    end
  end

  stp_one_cycle: assert property (@(posedge clock) disable iff (reset) stp_i |=> !stp_i)
    else $error("stp held for more than one cycle");

  data_zero_on_dir: assert property (@(posedge clock) disable iff (reset)
    dir_i |-> data_i == 8'h00)
    else $error("link drove the data bus while dir was high");

  done_after_valid: assert property (@(posedge clock) disable iff (reset)
    cmd_done_i |-> pending)
    else $error("cmd_done without a command");

endmodule

bind ulpi_reg_writer ulpi_line_properties i_properties (
  .clock       (clock),
  .reset       (reset),
  .dir_i       (ulpi_dir_i),
  .stp_i       (ulpi_stp_o),
  .data_i      (ulpi_data_o),
  .cmd_valid_i (cmd_valid_i),
  .cmd_done_i  (cmd_done_o)
);

//--- verilog/line_state.sv
module line_state
  import ulpi_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  rx_cmd_t     line_i,
  input  logic        ls_changed_i,
  input  line_ticks_t ticks_i,
  input  logic        cmd_done_i,
  output logic        cmd_valid_o,
  output phy_cmd_t    cmd_o,
  output logic        cmd_stop_o,
  output logic        fs_restart_o,
  output logic        high_speed_o,
  output logic        usb_reset_o,
  output logic        idle_o,
  output phy_state_t  phy_state_o
);

  phy_state_t state;
  phy_cmd_t   state_cmd;
  logic       writing;
  logic       sent;
  logic [1:0] k_pulses;
  logic [1:0] j_count;
  logic       kj_tick;

  function automatic phy_cmd_t reg_write(input logic [7:0] reg_addr, input logic [7:0] value);
    return '{nopid: 1'b0, addr: reg_addr, data: value};
  endfunction

  // Command owned by each state that talks to the PHY
  always_comb begin
    case (state)
      POWER_ON:   state_cmd = reg_write(OTG_CTRL_WR, OTG_CTRL_VAL);
      CHIRP_MODE: state_cmd = reg_write(FUNC_CTRL_WR, FUNC_CHIRP);
      CHIRP_K:    state_cmd = '{nopid: 1'b1, addr: TXCMD_NOPID, data: 8'h00};
      HS_START:   state_cmd = reg_write(FUNC_CTRL_WR, FUNC_HS);
      default:    state_cmd = reg_write(FUNC_CTRL_WR, FUNC_FS);
    endcase
  end

  assign writing     = state inside {POWER_ON, FS_START, CHIRP_MODE, CHIRP_K, HS_START};
  assign idle_o      = (state == IDLE);
  assign phy_state_o = state;

  always_ff @(posedge clock) begin
    cmd_o <= state_cmd;
  end

  always_ff @(posedge clock) begin
    cmd_valid_o  <= 1'b0;
    cmd_stop_o   <= 1'b0;
    fs_restart_o <= 1'b0;
    if (reset) begin
      state        <= POWER_ON;
      sent         <= 1'b0;
      high_speed_o <= 1'b0;
      usb_reset_o  <= 1'b0;
      k_pulses     <= 2'd0;
      j_count      <= 2'd0;
      kj_tick      <= 1'b0;
    end else begin
      // Each writing state issues one command and waits for cmd_done
      if (writing && !sent) begin
        cmd_valid_o <= 1'b1;
        sent        <= 1'b1;
      end

      case (state)
        POWER_ON: begin
          if (cmd_done_i) begin
            sent  <= 1'b0;
            state <= FS_START;
          end
        end
        FS_START: begin
          if (cmd_done_i) begin
            sent         <= 1'b0;
            fs_restart_o <= 1'b1;
            state        <= FS_WAIT;
          end
        end
        FS_WAIT: begin
          if (line_i.line_state == SE0) begin
            state <= WAIT_SE0;
          end else if (ticks_i.fs_timeout) begin
            usb_reset_o <= 1'b0;
            state       <= IDLE;
          end
        end
        WAIT_SE0: begin
          if (ls_changed_i) begin
            state <= FS_WAIT;
          end else if (ticks_i.tick) begin
            state <= CHIRP_MODE;
          end
        end
        CHIRP_MODE: begin
          if (cmd_done_i) begin
            sent     <= 1'b0;
            k_pulses <= 2'd0;
            state    <= CHIRP_K;
          end
        end
        CHIRP_K: begin
          // Timer phase is unknown on entry, so the second 1 ms pulse ends the chirp
          if (ticks_i.stable_1ms && k_pulses != 2'd2) begin
            k_pulses   <= k_pulses + 2'd1;
            cmd_stop_o <= (k_pulses == 2'd1);
          end
          if (cmd_done_i) begin
            sent    <= 1'b0;
            j_count <= 2'd0;
            kj_tick <= 1'b0;
            state   <= CHIRP_KJ;
          end
        end
        CHIRP_KJ: begin
          if (ls_changed_i) begin
            kj_tick <= 1'b0;
            if (line_i.line_state == J && j_count != 2'd3) begin
              j_count <= j_count + 2'd1;
            end
          end else if (ticks_i.tick) begin
            kj_tick <= 1'b1;
            // Third J has lasted a full tick
            if (kj_tick && j_count == 2'd3 && line_i.line_state == J) begin
              state <= HS_START;
            end
          end
        end
        HS_START: begin
          if (cmd_done_i) begin
            sent         <= 1'b0;
            high_speed_o <= 1'b1;
            usb_reset_o  <= 1'b0;
            state        <= IDLE;
          end
        end
        IDLE: begin
          if (ticks_i.stable_3ms && line_i.line_state == SE0) begin
            state <= RESET;
          end else if (ticks_i.stable_3ms && line_i.line_state == J) begin
            state <= SUSPEND;
          end
        end
        RESET: begin
          usb_reset_o <= 1'b1;
          if (ticks_i.tick) begin
            high_speed_o <= 1'b0;
            state        <= FS_START;
          end
        end
        SUSPEND: begin
          if (line_i.line_state != J) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= POWER_ON;
        end
      endcase
    end
  end

endmodule

//--- verilog/line_timers.sv
module line_timers
  import ulpi_pkg::*;
#(
  parameter int TICK_CYCLES   = 150,
  parameter int FS_WAIT_TICKS = 40,
  parameter int MS_TICKS      = 400
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        fs_restart_i,
  input  logic        ls_changed_i,
  output line_ticks_t ticks_o
);

  localparam int TICK_W = $clog2(TICK_CYCLES + 1);
  localparam int FS_W   = $clog2(FS_WAIT_TICKS + 1);
  localparam int MS_W   = $clog2(MS_TICKS + 1);

  logic [TICK_W-1:0] tick_cnt;
  logic [FS_W-1:0]   fs_cnt;
  logic [MS_W-1:0]   ms_cnt;
  logic [1:0]        ms3_cnt;
  logic              fs_run;
  logic              tick_q;
  logic              fs_timeout_q;
  logic              stable_1ms_q;
  logic              stable_3ms_q;

  assign ticks_o = '{
    tick:       tick_q,
    fs_timeout: fs_timeout_q,
    stable_1ms: stable_1ms_q,
    stable_3ms: stable_3ms_q
  };

  // Free-running 2.5 us tick
  always_ff @(posedge clock) begin
    if (reset) begin
      tick_cnt <= '0;
      tick_q   <= 1'b0;
    end else if (tick_cnt == TICK_W'(TICK_CYCLES - 1)) begin
      tick_cnt <= '0;
      tick_q   <= 1'b1;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
      tick_q   <= 1'b0;
    end
  end

  // One-shot full-speed wait, armed by fs_restart_i
  always_ff @(posedge clock) begin
    fs_timeout_q <= 1'b0;
    if (reset) begin
      fs_run <= 1'b0;
      fs_cnt <= '0;
    end else if (fs_restart_i) begin
      fs_run <= 1'b1;
      fs_cnt <= '0;
    end else if (fs_run && tick_q) begin
      if (fs_cnt == FS_W'(FS_WAIT_TICKS - 1)) begin
        fs_run       <= 1'b0;
        fs_timeout_q <= 1'b1;
      end else begin
        fs_cnt <= fs_cnt + 1'b1;
      end
    end
  end

  // Line stability, 1 ms pulses repeat while the line holds
  always_ff @(posedge clock) begin
    stable_1ms_q <= 1'b0;
    stable_3ms_q <= 1'b0;
    if (reset || ls_changed_i) begin
      ms_cnt  <= '0;
      ms3_cnt <= 2'd0;
    end else if (tick_q) begin
      if (ms_cnt == MS_W'(MS_TICKS - 1)) begin
        ms_cnt       <= '0;
        stable_1ms_q <= 1'b1;
        if (ms3_cnt == 2'd2) begin
          ms3_cnt      <= 2'd0;
          stable_3ms_q <= 1'b1;
        end else begin
          ms3_cnt <= ms3_cnt + 2'd1;
        end
      end else begin
        ms_cnt <= ms_cnt + 1'b1;
      end
    end
  end

endmodule

//--- verilog/ulpi_line_top.sv
module ulpi_line_top
  import ulpi_pkg::*;
#(
  parameter int TICK_CYCLES   = 150,
  parameter int FS_WAIT_TICKS = 40,
  parameter int MS_TICKS      = 400
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       ulpi_dir_i,
  input  logic       ulpi_nxt_i,
  input  logic [7:0] ulpi_data_i,
  output logic [7:0] ulpi_data_o,
  output logic       ulpi_stp_o,
  input  logic       usb_sof_i,
  output logic       high_speed_o,
  output logic       usb_reset_o,
  output rx_cmd_t    line_o,
  output phy_state_t phy_state_o,
  output logic       idle_o
);

  logic        dir_q;
  logic        ls_changed;
  logic        fs_restart;
  logic        cmd_valid;
  logic        cmd_stop;
  logic        cmd_done;
  phy_cmd_t    cmd;
  line_ticks_t ticks;

  ulpi_rx_cmd i_rx_cmd (
    .clock        (clock),
    .reset        (reset),
    .ulpi_dir_i   (ulpi_dir_i),
    .ulpi_nxt_i   (ulpi_nxt_i),
    .ulpi_data_i  (ulpi_data_i),
    .usb_sof_i    (usb_sof_i),
    .dir_q_o      (dir_q),
    .line_o       (line_o),
    .ls_changed_o (ls_changed)
  );

  line_timers #(
    .TICK_CYCLES   (TICK_CYCLES),
    .FS_WAIT_TICKS (FS_WAIT_TICKS),
    .MS_TICKS      (MS_TICKS)
  ) i_timers (
    .clock        (clock),
    .reset        (reset),
    .fs_restart_i (fs_restart),
    .ls_changed_i (ls_changed),
    .ticks_o      (ticks)
  );

  ulpi_reg_writer i_writer (
    .clock       (clock),
    .reset       (reset),
    .dir_q_i     (dir_q),
    .ulpi_dir_i  (ulpi_dir_i),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .cmd_stop_i  (cmd_stop),
    .cmd_done_o  (cmd_done),
    .ulpi_data_o (ulpi_data_o),
    .ulpi_stp_o  (ulpi_stp_o)
  );

  line_state i_line_state (
    .clock        (clock),
    .reset        (reset),
    .line_i       (line_o),
    .ls_changed_i (ls_changed),
    .ticks_i      (ticks),
    .cmd_done_i   (cmd_done),
    .cmd_valid_o  (cmd_valid),
    .cmd_o        (cmd),
    .cmd_stop_o   (cmd_stop),
    .fs_restart_o (fs_restart),
    .high_speed_o (high_speed_o),
    .usb_reset_o  (usb_reset_o),
    .idle_o       (idle_o),
    .phy_state_o  (phy_state_o)
  );

endmodule

//--- verilog/ulpi_pkg.sv
package ulpi_pkg;

  // USB line state as reported in bits [1:0] of an RX CMD
  typedef enum logic [1:0] {
    SE0 = 2'b00,
    J   = 2'b01,
    K   = 2'b10,
    SE1 = 2'b11
  } line_state_t;

  // Lower six bits of an RX CMD byte
  typedef struct packed {
    logic [1:0]  rx_event;
    logic [1:0]  vbus_state;
    line_state_t line_state;
  } rx_cmd_t;

  // One register write, or the NOPID chirp when nopid is set
  typedef struct packed {
    logic       nopid;
    logic [7:0] addr;
    logic [7:0] data;
  } phy_cmd_t;

  // Single-cycle timer pulses
  typedef struct packed {
    logic tick;
    logic fs_timeout;
    logic stable_1ms;
    logic stable_3ms;
  } line_ticks_t;

  typedef enum logic [3:0] {
    POWER_ON,
    FS_START,
    FS_WAIT,
    WAIT_SE0,
    CHIRP_MODE,
    CHIRP_K,
    CHIRP_KJ,
    HS_START,
    IDLE,
    RESET,
    SUSPEND
  } phy_state_t;

  // TX CMD bytes for register writes
  localparam logic [7:0] OTG_CTRL_WR  = 8'h8A;
  localparam logic [7:0] FUNC_CTRL_WR = 8'h84;

  // Function control values: FS, chirp and HS modes
  localparam logic [7:0] FUNC_FS      = 8'h45;
  localparam logic [7:0] FUNC_CHIRP   = 8'h54;
  localparam logic [7:0] FUNC_HS      = 8'h40;
  localparam logic [7:0] OTG_CTRL_VAL = 8'h00;

  localparam logic [7:0] TXCMD_NOPID  = 8'h40;

endpackage

//--- verilog/ulpi_reg_writer.sv
module ulpi_reg_writer
  import ulpi_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       dir_q_i,
  input  logic       ulpi_dir_i,
  input  logic       ulpi_nxt_i,
  input  logic       cmd_valid_i,
  input  phy_cmd_t   cmd_i,
  input  logic       cmd_stop_i,
  output logic       cmd_done_o,
  output logic [7:0] ulpi_data_o,
  output logic       ulpi_stp_o
);

  typedef enum logic [2:0] {
    W_IDLE,
    W_ADDR,
    W_DATA,
    W_CHIRP,
    W_STOP
  } wr_state_t;

  wr_state_t state;
  phy_cmd_t  cmd_q;
  logic      bus_busy;

  // PHY owns the bus while dir is high and during the turnaround after it
  assign bus_busy = ulpi_dir_i || dir_q_i;

  always_ff @(posedge clock) begin
    if (cmd_valid_i) begin
      cmd_q <= cmd_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= W_IDLE;
    end else begin
      case (state)
        W_IDLE: begin
          if (cmd_valid_i) begin
            state <= W_ADDR;
          end
        end
        // TX CMD byte, held until the PHY takes it
        W_ADDR: begin
          if (!bus_busy && ulpi_nxt_i) begin
            state <= cmd_q.nopid ? W_CHIRP : W_DATA;
          end
        end
        W_DATA: begin
          // Aborted by the PHY, start over from the TX CMD byte
          if (bus_busy) begin
            state <= W_ADDR;
          end else if (ulpi_nxt_i) begin
            state <= W_STOP;
          end
        end
        // Chirp K runs with zero on the bus until told to stop
        W_CHIRP: begin
          if (cmd_stop_i) begin
            state <= W_STOP;
          end
        end
        W_STOP: begin
          state <= W_IDLE;
        end
        default: begin
          state <= W_IDLE;
        end
      endcase
    end
  end

  always_comb begin
    ulpi_data_o = 8'h00;
    if (!bus_busy) begin
      if (state == W_ADDR) begin
        ulpi_data_o = cmd_q.addr;
      end else if (state == W_DATA) begin
        ulpi_data_o = cmd_q.data;
      end
    end
  end

  assign ulpi_stp_o = (state == W_STOP);
  assign cmd_done_o = (state == W_STOP);

endmodule

//--- verilog/ulpi_rx_cmd.sv
module ulpi_rx_cmd
  import ulpi_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       ulpi_dir_i,
  input  logic       ulpi_nxt_i,
  input  logic [7:0] ulpi_data_i,
  input  logic       usb_sof_i,
  output logic       dir_q_o,
  output rx_cmd_t    line_o,
  output logic       ls_changed_o
);

  logic       dir_q;
  logic       dir_qq;
  logic       nxt_q;
  logic [7:0] dat_q;
  logic       rx_cmd_q;
  rx_cmd_t    rx_byte_q;

  assign dir_q_o = dir_q;

  // Input registers, meant to sit in the IOBs
  always_ff @(posedge clock) begin
    if (reset) begin
      dir_q  <= 1'b0;
      dir_qq <= 1'b0;
      nxt_q  <= 1'b0;
    end else begin
      dir_q  <= ulpi_dir_i;
      dir_qq <= dir_q;
      nxt_q  <= ulpi_nxt_i;
    end
  end

  always_ff @(posedge clock) begin
    dat_q     <= ulpi_data_i;
    rx_byte_q <= rx_cmd_t'(dat_q[5:0]);
  end

  // The first cycle of dir high is turnaround, so an RX CMD needs dir held
  always_ff @(posedge clock) begin
    if (reset) begin
      rx_cmd_q <= 1'b0;
    end else begin
      rx_cmd_q <= dir_q && dir_qq && !nxt_q;
    end
  end

  // SOF activity also counts as a change, so the stability timers restart
  always_ff @(posedge clock) begin
    if (reset) begin
      line_o       <= '{rx_event: 2'b00, vbus_state: 2'b00, line_state: K};
      ls_changed_o <= 1'b0;
    end else begin
      ls_changed_o <= (rx_cmd_q && rx_byte_q.line_state != line_o.line_state) || usb_sof_i;
      if (rx_cmd_q) begin
        line_o <= rx_byte_q;
      end
    end
  end

endmodule
